//--- design/cpu_defs.svh
// Core-wide widths and fixed addresses for the 16-bit pipelined CPU
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Data path and instruction word width
`define CPU_XLEN      16

// Sixteen registers
`define CPU_RA_W      4

`define CPU_RESET_PC  16'h0000  // First fetch after reset

// CALL writes it, RET jumps through it
`define CPU_LINK_REG  4'd15

`endif

//--- design/cpu_pkg.sv
// Shared types of the CPU: opcodes, hazard states and the decoded instruction
`default_nettype none

`include "cpu_defs.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;      // One data word
    typedef logic [`CPU_RA_W-1:0] reg_addr_t;  // Register file index

    // Top nibble of the instruction word; codes C to E decode as NOP
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_SHL  = 4'h5,
        OP_ADDI = 4'h6,
        OP_LLB  = 4'h7,
        OP_LHB  = 4'h8,
        OP_CALL = 4'h9,
        OP_RET  = 4'hA,
        OP_HLT  = 4'hB,
        OP_NOP  = 4'hF
    } opcode_e;

    typedef enum logic {
        HZ_RUN,      // Fetch free
        HZ_WAIT_PC   // CALL/RET in flight
    } hz_state_e;

    typedef struct packed {
        opcode_e    op;
        reg_addr_t  rd;     // Link register for CALL
        reg_addr_t  rs;
        reg_addr_t  rt;
        logic [7:0] imm8;   // LLB/LHB byte
        logic [11:0] imm12; // CALL offset
        logic       wr;     // Writes rd
    } dec_instr_t;

endpackage

`default_nettype wire

//--- design/cpu_top.sv
// CPU top: decode, execute and result stages joined by the pipeline buses
`timescale 1ns/1ns
`include "cpu_defs.svh"
`default_nettype none

module cpu_top (
    input  logic                 clk,
    input  logic                 rst,
    output logic [`CPU_XLEN-1:0] imem_addr,
    input  logic [`CPU_XLEN-1:0] imem_data,  // Valid in the same cycle
    output logic                 res_valid,
    input  logic                 res_ready,
    output logic [`CPU_RA_W-1:0] res_rd,
    output logic [`CPU_XLEN-1:0] res_data,
    output logic                 halted
);

    logic                 stall;
    logic                 pc_update;
    logic [`CPU_XLEN-1:0] new_pc;
    logic                 wb_en;
    logic [`CPU_RA_W-1:0] wb_addr;
    logic [`CPU_XLEN-1:0] wb_data;

    dec_exe_if dx_bus ();
    exe_res_if xr_bus ();

    decode_stage u_decode (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .pc_update (pc_update),
        .new_pc    (new_pc),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .res_valid (res_valid),
        .res_rd    (res_rd),
        .dx        (dx_bus.dec),
        .dx_mon    (dx_bus.mon),
        .rs_stage  (xr_bus.mon)
    );

    execute_stage u_execute (
        .clk       (clk),
        .rst       (rst),
        .dx        (dx_bus.exe),
        .xr        (xr_bus.exe),
        .pc_update (pc_update),
        .new_pc    (new_pc)
    );

    result_stage u_result (
        .clk       (clk),
        .rst       (rst),
        .xr        (xr_bus.res),
        .res_ready (res_ready),
        .res_valid (res_valid),
        .res_rd    (res_rd),
        .res_data  (res_data),
        .halted    (halted),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .stall     (stall)
    );

endmodule

`default_nettype wire

//--- design/decode_stage.sv
// Decode stage: fetch counter, IF/ID, register file, decode and the ID/EX register
`timescale 1ns/1ns
`include "cpu_defs.svh"
`default_nettype none

module decode_stage import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,
    output logic [`CPU_XLEN-1:0] imem_addr,
    input  logic [`CPU_XLEN-1:0] imem_data,
    input  logic                 pc_update,
    input  logic [`CPU_XLEN-1:0] new_pc,
    input  logic                 wb_en,
    input  logic [`CPU_RA_W-1:0] wb_addr,
    input  logic [`CPU_XLEN-1:0] wb_data,
    input  logic                 res_valid,
    input  logic [`CPU_RA_W-1:0] res_rd,
    dec_exe_if.dec               dx,
    dec_exe_if.mon               dx_mon,
    exe_res_if.mon               rs_stage
);

    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] ifid_instr;
    logic [`CPU_XLEN-1:0] ifid_pc;
    logic                 ifid_valid;
    logic                 hlt_seen;   // HLT decoded, fetch stays off
    logic [`CPU_XLEN-1:0] regfile [2**`CPU_RA_W];
    dec_instr_t           id_instr;
    logic [`CPU_RA_W-1:0] rs_sel;
    logic                 data_hazard;
    logic                 pc_hazard;
    logic                 fetch;

    function automatic dec_instr_t decode_instr(input logic [`CPU_XLEN-1:0] raw,
                                                input logic vld);
        dec_instr_t d;
        d.rd    = raw[11:8];
        d.rs    = raw[7:4];
        d.rt    = raw[3:0];
        d.imm8  = raw[7:0];
        d.imm12 = raw[11:0];
        case (raw[15:12])
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_ADDI, OP_LLB,
            OP_LHB, OP_CALL, OP_RET, OP_HLT: d.op = opcode_e'(raw[15:12]);
            default:                         d.op = OP_NOP;
        endcase
        if (!vld) begin
            d.op = OP_NOP;  // Bubble
        end
        if (d.op == OP_CALL) begin
            d.rd = `CPU_LINK_REG;
        end
        d.wr = d.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL,
                            OP_ADDI, OP_LLB, OP_LHB, OP_CALL};
        return d;
    endfunction

    assign id_instr = decode_instr(ifid_instr, ifid_valid);
    assign rs_sel   = (id_instr.op == OP_RET) ? `CPU_LINK_REG : id_instr.rs;

    // Jump target is fetched in the same cycle it arrives
    assign imem_addr = pc_update ? new_pc : pc;
    assign fetch     = !stall && !data_hazard && !pc_hazard && !hlt_seen &&
                       (id_instr.op != OP_HLT);

    hazard_unit u_hazard (
        .clk         (clk),
        .rst         (rst),
        .instr       (id_instr),
        .ex          (dx_mon),
        .rs_stage    (rs_stage),
        .wb_valid    (res_valid),
        .wb_we       (1'b1),        // Result register only holds writers
        .wb_rd       (res_rd),
        .pc_update   (pc_update),
        .data_hazard (data_hazard),
        .pc_hazard   (pc_hazard)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= `CPU_RESET_PC;
            ifid_valid <= 1'b0;
            hlt_seen   <= 1'b0;
        end else begin
            if (fetch) begin
                pc <= imem_addr + 1'b1;
            end else if (pc_update) begin
                pc <= new_pc;       // Stalled, fetch new_pc later
            end
            if (!stall && !data_hazard) begin
                ifid_valid <= fetch;
                if (id_instr.op == OP_HLT) begin
                    hlt_seen <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch) begin
            ifid_instr <= imem_data;
            ifid_pc    <= imem_addr;
        end
        if (wb_en) begin
            regfile[wb_addr] <= wb_data;
        end
    end

    // ID/EX register, a bubble goes in on a data hazard
    always_ff @(posedge clk) begin
        if (rst) begin
            dx.valid <= 1'b0;
        end else if (!stall) begin
            dx.valid <= ifid_valid && !data_hazard;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && !data_hazard) begin
            dx.instr <= id_instr;
            dx.a     <= regfile[rs_sel];
            dx.b     <= regfile[id_instr.rt];
            dx.d     <= regfile[id_instr.rd];
            dx.pc    <= ifid_pc;
        end
    end

    assign dx.stall = stall;

endmodule

`default_nettype wire

//--- design/execute_stage.sv
// Execute stage: ALU, byte loads, CALL/RET targets and the EX/RS register
`timescale 1ns/1ns
`include "cpu_defs.svh"
`default_nettype none

module execute_stage import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    dec_exe_if.exe               dx,
    exe_res_if.exe               xr,
    output logic                 pc_update,
    output logic [`CPU_XLEN-1:0] new_pc
);

    logic [`CPU_XLEN-1:0] alu_out;
    logic [`CPU_XLEN-1:0] target;
    logic [`CPU_XLEN-1:0] imm4_ext;
    logic [`CPU_XLEN-1:0] imm12_ext;
    logic                 is_jump;
    logic                 advance;

    assign imm4_ext  = {{(`CPU_XLEN-`CPU_RA_W){dx.instr.rt[`CPU_RA_W-1]}}, dx.instr.rt};
    assign imm12_ext = {{(`CPU_XLEN-12){dx.instr.imm12[11]}}, dx.instr.imm12};
    assign is_jump   = (dx.instr.op == OP_CALL) || (dx.instr.op == OP_RET);
    assign advance   = !dx.stall;

    always_comb begin
        case (dx.instr.op)
            OP_ADD:  alu_out = dx.a + dx.b;
            OP_SUB:  alu_out = dx.a - dx.b;
            OP_AND:  alu_out = dx.a & dx.b;
            OP_OR:   alu_out = dx.a | dx.b;
            OP_XOR:  alu_out = dx.a ^ dx.b;
            OP_SHL:  alu_out = dx.a << dx.b[3:0];
            OP_ADDI: alu_out = dx.a + imm4_ext;
            OP_LLB:  alu_out = {{(`CPU_XLEN-8){1'b0}}, dx.instr.imm8};
            OP_LHB:  alu_out = {dx.instr.imm8, dx.d[7:0]};  // Keep the low byte
            OP_CALL: alu_out = dx.pc + 1'b1;                 // Link value
            default: alu_out = '0;
        endcase
    end

    // CALL is PC relative, RET goes through the link register
    assign target = (dx.instr.op == OP_CALL) ? dx.pc + imm12_ext : dx.a;

    always_ff @(posedge clk) begin
        if (rst) begin
            xr.valid  <= 1'b0;
            pc_update <= 1'b0;
        end else begin
            pc_update <= advance && dx.valid && is_jump;  // One cycle per jump
            if (advance) begin
                xr.valid <= dx.valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            xr.rd   <= dx.instr.rd;
            xr.we   <= dx.instr.wr;
            xr.data <= alu_out;
            xr.halt <= (dx.instr.op == OP_HLT);
        end
        if (advance && dx.valid && is_jump) begin
            new_pc <= target;
        end
    end

endmodule

`default_nettype wire

//--- design/hazard_unit.sv
// Hazard unit: read-after-write stall against three stages and the PC wait FSM
`timescale 1ns/1ns
`include "cpu_defs.svh"
`default_nettype none

module hazard_unit import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  dec_instr_t           instr,      // Instruction sitting in IF/ID
    dec_exe_if.mon               ex,
    exe_res_if.mon               rs_stage,
    input  logic                 wb_valid,
    input  logic                 wb_we,
    input  logic [`CPU_RA_W-1:0] wb_rd,
    input  logic                 pc_update,
    output logic                 data_hazard,
    output logic                 pc_hazard
);

    hz_state_e            state;
    hz_state_e            state_nxt;
    logic                 use_rs;
    logic                 use_rt;
    logic                 use_rd;
    logic [`CPU_RA_W-1:0] src_a;
    logic                 is_jump;
    logic                 ex_hit;
    logic                 rs_hit;
    logic                 wb_hit;

    // True when the IF/ID instruction reads register dst
    function automatic logic reads(input logic [`CPU_RA_W-1:0] dst);
        return (use_rs && src_a == dst) ||
               (use_rt && instr.rt == dst) ||
               (use_rd && instr.rd == dst);
    endfunction

    // Which fields the opcode actually reads
    always_comb begin
        use_rs = 1'b0;
        use_rt = 1'b0;
        use_rd = 1'b0;
        case (instr.op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL: begin
                use_rs = 1'b1;
                use_rt = 1'b1;
            end
            OP_ADDI, OP_RET: use_rs = 1'b1;
            OP_LHB:          use_rd = 1'b1;  // Low byte kept
            default:         ;
        endcase
    end

    assign src_a   = (instr.op == OP_RET) ? `CPU_LINK_REG : instr.rs;
    assign is_jump = (instr.op == OP_CALL) || (instr.op == OP_RET);

    always_comb begin
        ex_hit      = ex.valid && ex.instr.wr && reads(ex.instr.rd);
        rs_hit      = rs_stage.valid && rs_stage.we && reads(rs_stage.rd);
        wb_hit      = wb_valid && wb_we && reads(wb_rd);
        data_hazard = ex_hit || rs_hit || wb_hit;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            HZ_RUN:     if (is_jump && !data_hazard) state_nxt = HZ_WAIT_PC;
            HZ_WAIT_PC: if (pc_update) state_nxt = HZ_RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= HZ_RUN;
        end else begin
            state <= state_nxt;
        end
    end

    // Fetch is released in the pc_update cycle itself
    assign pc_hazard = is_jump || (state == HZ_WAIT_PC && !pc_update);

endmodule

`default_nettype wire

//--- design/pipe_if.sv
// Pipeline buses from decode to execute and from execute to the result stage
`timescale 1ns/1ns
`include "cpu_defs.svh"
`default_nettype none

interface dec_exe_if import cpu_pkg::*; ();

    logic                 valid;  // ID/EX holds a live instruction
    dec_instr_t           instr;
    logic [`CPU_XLEN-1:0] a;      // rs value, link register for RET
    logic [`CPU_XLEN-1:0] b;      // rt value
    logic [`CPU_XLEN-1:0] d;      // Old rd value for LHB
    logic [`CPU_XLEN-1:0] pc;     // Address of this instruction
    logic                 stall;  // Output back-pressure, freezes everything

    modport dec (output valid, instr, a, b, d, pc, stall);

    modport exe (input valid, instr, a, b, d, pc, stall);

    // Hazard compare only needs the destination
    modport mon (input valid, instr);

endinterface

interface exe_res_if ();

    logic                 valid;  // EX/RS holds a live instruction
    logic [`CPU_RA_W-1:0] rd;
    logic                 we;     // Result goes to the register file
    logic [`CPU_XLEN-1:0] data;
    logic                 halt;   // HLT reached EX/RS

    modport exe (output valid, rd, we, data, halt);

    modport res (input valid, rd, we, data, halt);

    modport mon (input valid, rd, we);

endinterface

`default_nettype wire

//--- design/result_stage.sv
// Result stage: one-entry output register with valid/ready, write-back and halt
`timescale 1ns/1ns
`include "cpu_defs.svh"
`default_nettype none

module result_stage (
    input  logic                 clk,
    input  logic                 rst,
    exe_res_if.res               xr,
    input  logic                 res_ready,
    output logic                 res_valid,
    output logic [`CPU_RA_W-1:0] res_rd,
    output logic [`CPU_XLEN-1:0] res_data,
    output logic                 halted,
    output logic                 wb_en,
    output logic [`CPU_RA_W-1:0] wb_addr,
    output logic [`CPU_XLEN-1:0] wb_data,
    output logic                 stall
);

    logic take;  // A writing instruction enters the output register

    // Held result not accepted, whole pipe waits
    assign stall = res_valid && !res_ready;
    assign take  = !stall && xr.valid && xr.we;

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
            halted    <= 1'b0;
        end else if (!stall) begin
            res_valid <= take;               // RET, NOP and HLT are dropped
            if (xr.valid && xr.halt) begin
                halted <= 1'b1;              // Everything older has transferred
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            res_rd   <= xr.rd;
            res_data <= xr.data;
        end
    end

    // Register file write on the transfer cycle
    assign wb_en   = res_valid && res_ready;
    assign wb_addr = res_rd;
    assign wb_data = res_data;

endmodule

`default_nettype wire

//--- verif/cpu_assertions.sv
// Result port checks: hold while stalled, reset values and sticky halt
`timescale 1ns/1ns
`include "cpu_defs.svh"
`default_nettype none

module cpu_assertions (
    input logic                 clk,
    input logic                 rst,
    input logic                 res_valid,
    input logic                 res_ready,
    input logic [`CPU_RA_W-1:0] res_rd,
    input logic [`CPU_XLEN-1:0] res_data,
    input logic                 halted
);

    int unsigned fail_count = 0;  // Read by the testbench at the end

    // Offered result stays put until it is taken
    a_hold: assert property (@(posedge clk) disable iff (rst)
        res_valid && !res_ready |=> res_valid && $stable(res_rd) && $stable(res_data))
    else begin
        fail_count++;
        $error("res_rd or res_data changed while held without res_ready");
    end

    a_reset: assert property (@(posedge clk) rst |=> !res_valid && !halted)
    else begin
        fail_count++;
        $error("res_valid or halted high after a reset cycle");
    end

    a_halt: assert property (@(posedge clk) halted && !rst |=> halted)
    else begin
        fail_count++;
        $error("halted fell without reset");
    end

endmodule

bind result_stage cpu_assertions u_sva (
    .clk       (clk),
    .rst       (rst),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_rd    (res_rd),
    .res_data  (res_data),
    .halted    (halted)
);

`default_nettype wire

//--- verif/cpu_tb.sv
// Testbench for the CPU: random programs checked against an architectural model
`timescale 1ns/1ns
`include "cpu_defs.svh"
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    localparam logic [16:0] SEED        = 17'd69954;
    localparam int          RES_TIMEOUT = 4000;  // Cycles per program
    localparam int          QUIET_WIN   = 20;

    logic                 clk;
    logic                 rst;
    logic [`CPU_XLEN-1:0] imem_addr;
    logic [`CPU_XLEN-1:0] imem_data;
    logic                 res_valid;
    logic                 res_ready;
    logic [`CPU_RA_W-1:0] res_rd;
    logic [`CPU_XLEN-1:0] res_data;
    logic                 halted;

    logic [16:0] lfsr;
    word_t       rom [0:1023];
    bit          made [0:1023];   // Entry already generated
    reg_addr_t   exp_rd [$];
    word_t       exp_data [$];
    int          errors;
    int          total_results;

    cpu_top DUT (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_rd    (res_rd),
        .res_data  (res_data),
        .halted    (halted)
    );

    // Instruction port answers in the same cycle
    assign imem_data = (imem_addr < 16'd1024) ? rom[imem_addr[9:0]] : 16'hF000;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    function logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[14:0], lfsr[16]};
            lfsr = lfsr_next(lfsr);
        end
        return r;
    endfunction

    task automatic compare_rd(input string sig, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, sig, exp, act);
            errors++;
        end
    endtask

    task automatic compare_data(input string sig, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, sig, exp, act);
            errors++;
        end
    endtask

    // Walks the program, creating each ROM word when first reached
    // Kinds: 0 dependent chain, 2 CALL/RET mix, 3 byte loads, 4 straight mix
    task automatic build_program(input int kind, input int n_ops);
        word_t      regs [16];
        word_t      pc;
        word_t      ins;
        word_t      val;
        logic [3:0] op;
        logic [3:0] rd;
        logic [3:0] rs;
        logic [3:0] rt;
        logic [3:0] last_rd;
        int         emitted;
        int         ops;
        int         steps;
        int         phase;      // 0 free, 1 in subroutine, 2 just returned
        int         body_left;
        bit         wr;
        bit         stop;
        for (int i = 0; i < 1024; i++) begin
            rom[i]  = {4'hF, 2'b00, i[9:0]};  // NOP fill
            made[i] = 1'b0;
        end
        exp_rd.delete();
        exp_data.delete();
        pc        = `CPU_RESET_PC;
        emitted   = 0;
        ops       = 0;
        steps     = 0;
        phase     = 0;
        body_left = 0;
        last_rd   = 4'd0;
        stop      = 1'b0;
        while (!stop && steps < 4096) begin
            if (!made[pc[9:0]]) begin
                if (emitted < 16) begin
                    ins = {OP_LLB, 4'(emitted), 8'(rand_bits(8))};  // Every register defined
                end else if (ops >= n_ops && phase == 0) begin
                    ins = {OP_HLT, 12'h000};
                end else if (phase == 1 && body_left == 0) begin
                    ins   = {OP_RET, 12'h000};
                    phase = 2;
                end else if (phase == 2) begin
                    ins   = {OP_CALL, 12'd5};  // Jumps past the subroutine just left
                    phase = 0;
                end else if (kind == 2 && phase == 0 && rand_bits(2) == 16'd0) begin
                    rt        = 4'(2 + rand_bits(2) % 3);
                    ins       = {OP_CALL, 8'h00, rt};
                    phase     = 1;
                    body_left = int'(rand_bits(2)) % (6 - int'(rt));  // RET before the return jump target
                end else begin
                    op = 4'(rand_bits(3));
                    rd = 4'(rand_bits(4));
                    rs = 4'(rand_bits(4));
                    rt = 4'(rand_bits(4));
                    if (rd == `CPU_LINK_REG) begin
                        rd = 4'd0;
                    end
                    case (kind)
                        0: begin
                            rs = last_rd;
                            if (op == OP_LLB) begin
                                op = OP_ADDI;
                            end
                        end
                        3: begin
                            op = (ops % 3 == 0) ? OP_LLB : (ops % 3 == 1) ? OP_LHB : OP_ADDI;
                            if (ops % 3 != 0) begin
                                rd = last_rd;
                                rs = last_rd;
                            end
                        end
                        4: begin
                            op = 4'(rand_bits(4));
                            if (op inside {OP_CALL, OP_RET, OP_HLT}) begin
                                op = 4'hC;
                            end
                        end
                        default: ;
                    endcase
                    if (phase == 1) begin
                        body_left--;
                    end
                    ins     = {op, rd, rs, rt};
                    last_rd = rd;
                    ops++;
                end
                rom[pc[9:0]]  = ins;
                made[pc[9:0]] = 1'b1;
                emitted++;
            end
            ins = rom[pc[9:0]];
            op  = ins[15:12];
            rd  = ins[11:8];
            rs  = ins[7:4];
            rt  = ins[3:0];
            wr  = 1'b1;
            val = '0;
            steps++;
            case (op)
                OP_ADD:  val = regs[rs] + regs[rt];
                OP_SUB:  val = regs[rs] - regs[rt];
                OP_AND:  val = regs[rs] & regs[rt];
                OP_OR:   val = regs[rs] | regs[rt];
                OP_XOR:  val = regs[rs] ^ regs[rt];
                OP_SHL:  val = regs[rs] << regs[rt][3:0];
                OP_ADDI: val = regs[rs] + {{12{rt[3]}}, rt};
                OP_LLB:  val = {8'h00, ins[7:0]};
                OP_LHB:  val = {ins[7:0], regs[rd][7:0]};
                OP_CALL: begin
                    rd  = `CPU_LINK_REG;
                    val = pc + 16'd1;
                end
                default: wr = 1'b0;
            endcase
            if (op == OP_CALL) begin
                pc = pc + {{4{ins[11]}}, ins[11:0]};
            end else if (op == OP_RET) begin
                pc = regs[`CPU_LINK_REG];
            end else begin
                pc = pc + 16'd1;
            end
            stop = (op == OP_HLT);
            if (wr) begin
                regs[rd] = val;
                exp_rd.push_back(rd);
                exp_data.push_back(val);
            end
        end
        if (!stop) begin
            $display("Generated program did not reach HLT within 4096 steps");
            errors++;
        end
    endtask

    task automatic run_test(input int test_no, input string name, input int kind,
                            input int n_ops, input bit backpressure, input bit reseed);
        int cycles;
        int got;
        int errs_before;
        bit done;
        errs_before = errors;
        got         = 0;
        done        = 1'b0;
        @(posedge clk);
        rst       <= 1'b1;
        res_ready <= 1'b0;
        if (reseed) begin
            lfsr = SEED;
        end
        build_program(kind, n_ops);
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
        end
        rst    <= 1'b0;
        cycles = 0;
        while (!done && cycles < RES_TIMEOUT) begin
            @(posedge clk);
            res_ready <= backpressure ? (rand_bits(1) != 16'd0) : 1'b1;
            @(negedge clk);
            cycles++;
            if (res_valid && res_ready) begin
                if (exp_rd.size() == 0) begin
                    $display("Unexpected result for register %0d at %0t ns", res_rd, $time);
                    errors++;
                end else begin
                    compare_rd("res_rd", exp_rd.pop_front(), res_rd);
                    compare_data("res_data", exp_data.pop_front(), res_data);
                    got++;
                end
            end
            if (halted) begin
                done = 1'b1;
                if (exp_rd.size() != 0) begin
                    $display("halted rose with %0d results still missing", exp_rd.size());
                    errors++;
                end
            end
        end
        if (!done) begin
            $display("Timeout in test %0d: halted never rose, %0d results missing",
                     test_no, exp_rd.size());
            errors++;
        end else begin
            for (int i = 0; i < QUIET_WIN; i++) begin
                @(posedge clk);
                res_ready <= 1'b1;
                @(negedge clk);
                if (res_valid) begin
                    $display("res_valid rose after halt at %0t ns", $time);
                    errors++;
                end
            end
        end
        total_results += got;
        $display("Test %0d %s: %0d results, %0d errors", test_no, name, got,
                 errors - errs_before);
    endtask

    initial begin
        rst           = 1'b1;
        res_ready     = 1'b0;
        lfsr          = SEED;
        errors        = 0;
        total_results = 0;
        run_test(1, "dependent ALU chain", 0, 64, 1'b0, 1'b1);
        run_test(2, "random back-pressure", 0, 64, 1'b1, 1'b1);
        run_test(3, "CALL/RET mix", 2, 48, 1'b0, 1'b0);
        run_test(4, "LLB/LHB/ADDI merge", 3, 48, 1'b0, 1'b0);
        run_test(5, "straight program to HLT", 4, 40, 1'b1, 1'b0);
        errors += int'(DUT.u_result.u_sva.fail_count);
        $display("Summary: 5 tests, %0d results checked, %0d errors", total_results, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+design
design/cpu_pkg.sv
design/pipe_if.sv
design/hazard_unit.sv
design/decode_stage.sv
design/execute_stage.sv
design/result_stage.sv
design/cpu_top.sv
verif/cpu_assertions.sv
verif/cpu_tb.sv
